/* Makefile */
VERILATOR ?= verilator
VFLAGS := --binary --timing --assert -j 0
TOP := tb_gm_packet_hub
FILELIST := gm_packet_hub.f
BUILD_DIR := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* gm_packet_hub.f */
hdl/gm_pkg.sv
hdl/pb_port_if.sv
hdl/packet_buffer.sv
hdl/buffer_arbiter.sv
hdl/rx_admit.sv
hdl/proc_exchange.sv
hdl/gm_packet_hub.sv
testbench/tb_gm_packet_hub.sv

/* hdl/buffer_arbiter.sv */
`timescale 1ns/1ps

module buffer_arbiter
	import gm_pkg::*;
	(
	input logic system_clk,
	input logic rst_n,
	input logic transmitting,
	input logic rx_claim,
	input logic sending,
	input logic receiving,
	pb_port_if.memory rx_pb,
	pb_port_if.memory tx_pb,
	pb_port_if.memory rd_pb,
	pb_port_if.memory wr_pb,
	pb_port_if.owner mem_pb
	);

	logic [OWN_W-1:0] owner; // Current buffer owner

	// Fixed priority, owner held when nobody asks
	always_ff @(posedge system_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			owner <= OWN_IDLE;
		end
		else if (transmitting)
		begin
			owner <= OWN_TX;
		end
		else if (rx_claim)
		begin
			owner <= OWN_RX; // Engine drains the receive FIFO here
		end
		else if (sending)
		begin
			owner <= OWN_PROC_READ;
		end
		else if (receiving)
		begin
			owner <= OWN_PROC_WRITE;
		end
	end

	// Owner's port onto the RAM
	always_comb
	begin
		mem_pb.address = '0; // Idle parks on word 0
		mem_pb.wdata = '0;
		mem_pb.wren = 1'b0;
		case (owner)
			OWN_TX:
			begin
				mem_pb.address = tx_pb.address;
				mem_pb.wdata = tx_pb.wdata;
				mem_pb.wren = tx_pb.wren;
			end
			OWN_RX:
			begin
				mem_pb.address = rx_pb.address;
				mem_pb.wdata = rx_pb.wdata;
				mem_pb.wren = rx_pb.wren;
			end
			OWN_PROC_READ:
			begin
				mem_pb.address = rd_pb.address;
				mem_pb.wdata = rd_pb.wdata;
				mem_pb.wren = rd_pb.wren;
			end
			OWN_PROC_WRITE:
			begin
				mem_pb.address = wr_pb.address;
				mem_pb.wdata = wr_pb.wdata;
				mem_pb.wren = wr_pb.wren;
			end
			default:
			begin
				mem_pb.wren = 1'b0; // Idle, nothing written
			end
		endcase
	end

	// Read word fans out to every client
	assign rx_pb.q = mem_pb.q;
	assign tx_pb.q = mem_pb.q;
	assign rd_pb.q = mem_pb.q;
	assign wr_pb.q = mem_pb.q;

endmodule

/* hdl/gm_packet_hub.sv */
`timescale 1ns/1ps

module gm_packet_hub
	import gm_pkg::*;
	(
	input logic system_clk,
	input logic rst_n,
	input logic round_start,
	input logic rx_empty, // Receive FIFO empty
	input logic rx_waiting,
	input logic rx_wren,
	input logic proc_ready,
	input logic proc_ack,
	input logic proc_data_ready,
	input logic proc_done,
	input logic tx_ready,
	input logic [PB_AW-1:0] rx_address,
	input logic [PB_AW-1:0] tx_address,
	input logic [PB_DW-1:0] rx_data,
	input logic [PB_DW-1:0] proc_wdata,
	output logic move_packet,
	output logic send_ship,
	output logic proc_request,
	output logic proc_valid,
	output logic proc_irq,
	output logic [PB_DW-1:0] pb_q,
	output logic [PB_DW-1:0] proc_data,
	output logic [DEST_W-1:0] dest_address,
	output logic [PB_AW-1:0] player_base
	);

	logic bus_free; // No round holding the buffer
	logic sending;
	logic receiving;
	logic transmitting;
	logic rx_claim;

	pb_port_if rx_pb (); // Receive engine
	pb_port_if tx_pb (); // Transmit engine
	pb_port_if rd_pb (); // Processor read-out
	pb_port_if wr_pb (); // Processor write-in
	pb_port_if mem_pb (); // RAM side

	// Engine ports onto their buffer clients
	assign rx_pb.address = rx_address;
	assign rx_pb.wdata = rx_data;
	assign rx_pb.wren = rx_wren;
	assign tx_pb.address = tx_address;
	assign tx_pb.wdata = '0;
	assign tx_pb.wren = 1'b0; // Transmit only reads
	assign pb_q = tx_pb.q;

	packet_buffer u_packet_buffer (
		.system_clk (system_clk),
		.pb (mem_pb.memory)
	);

	buffer_arbiter u_buffer_arbiter (
		.system_clk (system_clk),
		.rst_n (rst_n),
		.transmitting (transmitting),
		.rx_claim (rx_claim),
		.sending (sending),
		.receiving (receiving),
		.rx_pb (rx_pb.memory),
		.tx_pb (tx_pb.memory),
		.rd_pb (rd_pb.memory),
		.wr_pb (wr_pb.memory),
		.mem_pb (mem_pb.owner)
	);

	rx_admit u_rx_admit (
		.system_clk (system_clk),
		.rst_n (rst_n),
		.rx_empty (rx_empty),
		.bus_free (bus_free),
		.rx_waiting (rx_waiting),
		.rx_claim (rx_claim),
		.move_packet (move_packet)
	);

	proc_exchange u_proc_exchange (
		.system_clk (system_clk),
		.rst_n (rst_n),
		.round_start (round_start),
		.rx_empty (rx_empty),
		.proc_ready (proc_ready),
		.proc_ack (proc_ack),
		.proc_data_ready (proc_data_ready),
		.proc_done (proc_done),
		.tx_ready (tx_ready),
		.proc_wdata (proc_wdata),
		.bus_free (bus_free),
		.sending (sending),
		.receiving (receiving),
		.transmitting (transmitting),
		.proc_request (proc_request),
		.proc_valid (proc_valid),
		.proc_irq (proc_irq),
		.send_ship (send_ship),
		.proc_data (proc_data),
		.dest_address (dest_address),
		.player_base (player_base),
		.rd_pb (rd_pb.owner),
		.wr_pb (wr_pb.owner)
	);

endmodule

/* hdl/gm_pkg.sv */
package gm_pkg;

	localparam int PB_AW = 9; // Packet buffer address bits
	localparam int PB_DW = 16; // Packet buffer word bits
	localparam int PB_HALF = 256; // Start of processor read-out region
	localparam int PLAYER_BLOCK = 64; // Words sent to each player
	localparam int NUM_PLAYERS = 2;
	localparam int PLAYER_W = 2; // Player counter bits
	localparam int ROUND_WAIT = 200; // Countdown cycles before the interrupt
	localparam int TIMER_W = 8; // Holds ROUND_WAIT
	localparam int DEST_W = 48; // Ethernet destination address

	// Buffer owner codes
	localparam int OWN_W = 3;
	localparam logic [OWN_W-1:0] OWN_IDLE = 3'd0;
	localparam logic [OWN_W-1:0] OWN_TX = 3'd1;
	localparam logic [OWN_W-1:0] OWN_RX = 3'd2;
	localparam logic [OWN_W-1:0] OWN_PROC_READ = 3'd3;
	localparam logic [OWN_W-1:0] OWN_PROC_WRITE = 3'd4;

	// Round exchange states
	localparam int ST_W = 4;
	localparam logic [ST_W-1:0] ST_RESET_TIMER = 4'd0;
	localparam logic [ST_W-1:0] ST_COUNTDOWN = 4'd1;
	localparam logic [ST_W-1:0] ST_INTERRUPT = 4'd2;
	localparam logic [ST_W-1:0] ST_INIT_SEND = 4'd3;
	localparam logic [ST_W-1:0] ST_READ_PB = 4'd4;
	localparam logic [ST_W-1:0] ST_SEND = 4'd5;
	localparam logic [ST_W-1:0] ST_WAIT_ACK = 4'd6;
	localparam logic [ST_W-1:0] ST_INIT_RECEIVE = 4'd7;
	localparam logic [ST_W-1:0] ST_RECEIVE_PACKETS = 4'd8;
	localparam logic [ST_W-1:0] ST_WAIT_UNTIL_LOW = 4'd9;
	localparam logic [ST_W-1:0] ST_RECEIVE_WRITE = 4'd10;
	localparam logic [ST_W-1:0] ST_NEXT_ADDRESS = 4'd11;
	localparam logic [ST_W-1:0] ST_TRANSMIT_PLAYERS = 4'd12;
	localparam logic [ST_W-1:0] ST_REQUEST_TX = 4'd13;
	localparam logic [ST_W-1:0] ST_TX_COMPLETE = 4'd14;
	localparam logic [ST_W-1:0] ST_TX_NEXT = 4'd15;

	// Receive admission states
	localparam int RX_ST_W = 2;
	localparam logic [RX_ST_W-1:0] RX_NEXT = 2'd0;
	localparam logic [RX_ST_W-1:0] RX_WAIT = 2'd1;
	localparam logic [RX_ST_W-1:0] RX_START = 2'd2;
	localparam logic [RX_ST_W-1:0] RX_DO = 2'd3;

endpackage

/* hdl/packet_buffer.sv */
`timescale 1ns/1ps

module packet_buffer
	import gm_pkg::*;
	(
	input logic system_clk,
	pb_port_if.memory pb
	);

	logic [PB_DW-1:0] mem [0:(1 << PB_AW)-1]; // Packet storage, 512 words
	logic [PB_AW-1:0] addr_q; // Registered read address

	always_ff @(posedge system_clk)
	begin
		if (pb.wren)
		begin
			mem[pb.address] <= pb.wdata; // Write at the edge
		end
		addr_q <= pb.address; // Address sampled every clock
	end

	// Word at the sampled address one cycle after the address
	assign pb.q = mem[addr_q];

endmodule

/* hdl/pb_port_if.sv */
`timescale 1ns/1ps

interface pb_port_if
	import gm_pkg::*;
	();

	logic [PB_AW-1:0] address; // Word address into the buffer
	logic [PB_DW-1:0] wdata; // Write word
	logic wren; // Write strobe
	logic [PB_DW-1:0] q; // Read word, one cycle behind address

	// Client side of the buffer
	modport owner (output address, output wdata, output wren, input q);

	// RAM side, also used by the arbiter toward each client
	modport memory (input address, input wdata, input wren, output q);

endinterface

/* hdl/proc_exchange.sv */
`timescale 1ns/1ps

module proc_exchange
	import gm_pkg::*;
	(
	input logic system_clk,
	input logic rst_n,
	input logic round_start,
	input logic rx_empty,
	input logic proc_ready,
	input logic proc_ack,
	input logic proc_data_ready,
	input logic proc_done,
	input logic tx_ready,
	input logic [PB_DW-1:0] proc_wdata,
	output logic bus_free,
	output logic sending,
	output logic receiving,
	output logic transmitting,
	output logic proc_request,
	output logic proc_valid,
	output logic proc_irq,
	output logic send_ship,
	output logic [PB_DW-1:0] proc_data,
	output logic [DEST_W-1:0] dest_address,
	output logic [PB_AW-1:0] player_base,
	pb_port_if.owner rd_pb,
	pb_port_if.owner wr_pb
	);

	logic [ST_W-1:0] state;
	logic [TIMER_W-1:0] timer; // Round countdown
	logic [PB_AW-1:0] count; // Read-out word counter
	logic [PB_AW-1:0] wr_addr; // Write-in word address
	logic wr_en;
	logic [PB_DW-1:0] wr_data; // Word captured from the processor
	logic [PLAYER_W-1:0] player; // Player being served

	assign rd_pb.address = count; // Held through read_pb
	assign rd_pb.wdata = '0;
	assign rd_pb.wren = 1'b0; // Read-only client
	assign wr_pb.address = wr_addr;
	assign wr_pb.wdata = wr_data;
	assign wr_pb.wren = wr_en;

	always_ff @(posedge system_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= ST_RESET_TIMER;
			timer <= '0;
			count <= '0;
			wr_addr <= '0;
			wr_en <= 1'b0;
			player <= '0;
			bus_free <= 1'b1;
			sending <= 1'b0;
			receiving <= 1'b0;
			transmitting <= 1'b0;
			proc_request <= 1'b0;
			proc_valid <= 1'b0;
			proc_irq <= 1'b0;
			send_ship <= 1'b0;
		end
		else
		begin
			proc_irq <= 1'b0; // Both are single-cycle pulses
			send_ship <= 1'b0;
			case (state)
				ST_RESET_TIMER:
				begin
					timer <= '0;
					bus_free <= 1'b1; // Receive side may use the buffer
					transmitting <= 1'b0;
					state <= round_start ? ST_COUNTDOWN : ST_RESET_TIMER;
				end
				ST_COUNTDOWN:
				begin
					if (timer != TIMER_W'(ROUND_WAIT))
					begin
						timer <= timer + 1'b1; // Saturates at the end value
					end
					count <= PB_AW'(PB_HALF);
					if (timer == TIMER_W'(ROUND_WAIT) && rx_empty)
					begin
						state <= ST_INTERRUPT; // Only with the receive FIFO drained
					end
				end
				ST_INTERRUPT:
				begin
					proc_irq <= 1'b1;
					proc_request <= 1'b1;
					bus_free <= 1'b0; // Locks out receive admission
					sending <= 1'b1;
					state <= ST_INIT_SEND;
				end
				ST_INIT_SEND:
				begin
					if (proc_ready)
					begin
						proc_request <= 1'b0;
						state <= ST_READ_PB;
					end
				end
				ST_READ_PB:
				begin
					state <= proc_ack ? ST_READ_PB : ST_SEND; // Previous ack must drop
				end
				ST_SEND:
				begin
					proc_valid <= 1'b1; // Word latched below
					count <= count + 1'b1;
					state <= ST_WAIT_ACK;
				end
				ST_WAIT_ACK:
				begin
					if (proc_ack)
					begin
						proc_valid <= 1'b0;
						state <= (count == '0) ? ST_INIT_RECEIVE : ST_READ_PB; // Wrapped past 511
					end
				end
				ST_INIT_RECEIVE:
				begin
					sending <= 1'b0;
					receiving <= 1'b1;
					wr_addr <= '0;
					wr_en <= 1'b0;
					player <= '0;
					state <= ST_RECEIVE_PACKETS;
				end
				ST_RECEIVE_PACKETS:
				begin
					if (proc_done)
					begin
						state <= ST_TRANSMIT_PLAYERS;
					end
					else if (proc_data_ready)
					begin
						state <= ST_WAIT_UNTIL_LOW;
					end
				end
				ST_WAIT_UNTIL_LOW:
				begin
					state <= proc_data_ready ? ST_WAIT_UNTIL_LOW : ST_RECEIVE_WRITE;
				end
				ST_RECEIVE_WRITE:
				begin
					wr_en <= 1'b1; // Written at the edge leaving next_address
					state <= ST_NEXT_ADDRESS;
				end
				ST_NEXT_ADDRESS:
				begin
					wr_en <= 1'b0;
					wr_addr <= wr_addr + 1'b1;
					state <= ST_RECEIVE_PACKETS;
				end
				ST_TRANSMIT_PLAYERS:
				begin
					receiving <= 1'b0;
					transmitting <= 1'b1;
					// Start only once the transmit request has been seen for a cycle
					if (tx_ready && transmitting)
					begin
						send_ship <= 1'b1;
						state <= ST_REQUEST_TX;
					end
				end
				ST_REQUEST_TX:
				begin
					state <= tx_ready ? ST_REQUEST_TX : ST_TX_COMPLETE; // Engine busy
				end
				ST_TX_COMPLETE:
				begin
					state <= tx_ready ? ST_TX_NEXT : ST_TX_COMPLETE; // Block sent
				end
				ST_TX_NEXT:
				begin
					player <= player + 1'b1;
					if (player == PLAYER_W'(NUM_PLAYERS - 1))
					begin
						state <= ST_RESET_TIMER;
					end
					else
					begin
						state <= ST_TRANSMIT_PLAYERS;
					end
				end
			endcase
		end
	end

	// Data path registers
	always_ff @(posedge system_clk)
	begin
		if (state == ST_SEND)
		begin
			proc_data <= rd_pb.q; // RAM word for the address held in read_pb
		end
		if ((state == ST_RECEIVE_PACKETS || state == ST_WAIT_UNTIL_LOW) && proc_data_ready)
		begin
			wr_data <= proc_wdata; // Last word seen while strobe high
		end
		if (state == ST_TRANSMIT_PLAYERS)
		begin
			dest_address <= DEST_W'(player) + DEST_W'(1); // Game master is address 0
			player_base <= PB_AW'(player) * PB_AW'(PLAYER_BLOCK);
		end
	end

endmodule

/* hdl/rx_admit.sv */
`timescale 1ns/1ps

module rx_admit
	import gm_pkg::*;
	(
	input logic system_clk,
	input logic rst_n,
	input logic rx_empty,
	input logic bus_free,
	input logic rx_waiting,
	output logic rx_claim,
	output logic move_packet
	);

	logic [RX_ST_W-1:0] state;

	// Packets pending and no round holding the buffer
	assign rx_claim = !rx_empty && bus_free;

	always_ff @(posedge system_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= RX_START;
			move_packet <= 1'b0;
		end
		else
		begin
			case (state)
				RX_START:
				begin
					if (rx_claim)
					begin
						state <= RX_WAIT;
						move_packet <= 1'b1; // Ask engine to move a packet
					end
				end
				RX_WAIT:
				begin
					if (rx_waiting)
					begin
						state <= RX_DO;
						move_packet <= 1'b0; // Engine took the request
					end
				end
				RX_DO:
				begin
					state <= rx_waiting ? RX_DO : RX_NEXT; // Wait for the low phase
				end
				RX_NEXT:
				begin
					state <= rx_waiting ? RX_START : RX_NEXT; // Re-arm on the rise
				end
			endcase
		end
	end

endmodule

/* testbench/tb_gm_packet_hub.sv */
`timescale 1ns/1ps

module tb_gm_packet_hub
	import gm_pkg::*;
	();

	localparam int DRIVE_DLY = 2; // Input skew after the rising edge
	localparam int WAIT_LIMIT = 2000; // Cycles allowed per wait
	localparam int WRITE_WORDS = 128; // Processor reply length

	logic system_clk;
	logic rst_n;
	logic round_start;
	logic rx_empty;
	logic rx_waiting;
	logic rx_wren;
	logic proc_ready;
	logic proc_ack;
	logic proc_data_ready;
	logic proc_done;
	logic tx_ready;
	logic [PB_AW-1:0] rx_address;
	logic [PB_AW-1:0] tx_address;
	logic [PB_DW-1:0] rx_data;
	logic [PB_DW-1:0] proc_wdata;
	logic move_packet;
	logic send_ship;
	logic proc_request;
	logic proc_valid;
	logic proc_irq;
	logic [PB_DW-1:0] pb_q;
	logic [PB_DW-1:0] proc_data;
	logic [DEST_W-1:0] dest_address;
	logic [PB_AW-1:0] player_base;

	logic [PB_DW-1:0] expected_mem [0:(1 << PB_AW)-1]; // Model of buffer contents
	int waited; // Cycles spent in the current wait

	gm_packet_hub uut (.*);

	always #20 system_clk = ~system_clk; // 40 ns period

	task automatic stop_run(input string line);
		$display("%s", line);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		assert (expected === actual)
		else stop_run($sformatf("ERR %s expected %0h actual %0h", name, expected, actual));
	endtask

	task automatic step();
		@(posedge system_clk);
		#DRIVE_DLY; // Drive and sample clear of the edge
	endtask

	task automatic timed_step(input string what);
		step();
		waited++;
		if (waited > WAIT_LIMIT)
		begin
			stop_run($sformatf("Timed out waiting for %s", what));
		end
	endtask

	// Control outputs stay low while reset is held
	assert property (@(posedge system_clk)
		!rst_n |-> !(proc_request || proc_valid || proc_irq || send_ship || move_packet))
	else stop_run("A control output was high during reset");

	assert property (@(posedge system_clk) disable iff (!rst_n) proc_irq |=> !proc_irq)
	else stop_run("proc_irq stayed high for more than one cycle");

	assert property (@(posedge system_clk) disable iff (!rst_n) send_ship |=> !send_ship)
	else stop_run("send_ship stayed high for more than one cycle");

	assert property (@(posedge system_clk) disable iff (!rst_n)
		$rose(rx_waiting) |=> !move_packet)
	else stop_run("move_packet did not fall after rx_waiting rose");

	// Word held steady until the processor acknowledges
	assert property (@(posedge system_clk) disable iff (!rst_n)
		proc_valid && !proc_ack |=> proc_valid && $stable(proc_data))
	else stop_run("proc_valid or proc_data changed before proc_ack");

	initial
	begin
		logic [PB_DW-1:0] word;
		int base;
		void'($urandom(32'h465f_b47a));
		system_clk = 1'b0;
		rst_n = 1'b0;
		round_start = 1'b0;
		rx_empty = 1'b1; // Receive FIFO starts drained
		rx_waiting = 1'b0;
		rx_wren = 1'b0;
		proc_ready = 1'b0;
		proc_ack = 1'b0;
		proc_data_ready = 1'b0;
		proc_done = 1'b0;
		tx_ready = 1'b1; // Transmit engine idle
		rx_address = '0;
		tx_address = '0;
		rx_data = '0;
		proc_wdata = '0;
		repeat (16) @(posedge system_clk);
		#DRIVE_DLY;
		rst_n = 1'b1;
		check_value("reset_controls", 64'd0,
			64'({proc_request, proc_valid, proc_irq, send_ship, move_packet}));

		// Receive engine fills the whole buffer with one packet burst
		rx_empty = 1'b0;
		waited = 0;
		while (!move_packet)
		begin
			timed_step("move_packet to rise");
		end
		rx_waiting = 1'b1; // Engine takes the request
		for (int a = 0; a < (1 << PB_AW); a++)
		begin
			word = PB_DW'($urandom());
			rx_address = PB_AW'(a);
			rx_data = word;
			rx_wren = 1'b1;
			expected_mem[a] = word;
			step();
		end
		check_value("rx_move_release", 64'd0, 64'(move_packet));
		rx_wren = 1'b0;
		rx_empty = 1'b1; // FIFO drained so the countdown can end
		rx_waiting = 1'b0;
		step();

		round_start = 1'b1;
		step();
		round_start = 1'b0;
		waited = 0;
		while (!proc_irq)
		begin
			timed_step("proc_irq");
		end
		check_value("irq_request", 64'd1, 64'(proc_request));
		proc_ready = 1'b1;
		waited = 0;
		while (proc_request)
		begin
			timed_step("proc_request to fall");
		end
		proc_ready = 1'b0;

		// Upper half arrives word by word
		for (int i = 0; i < PB_HALF; i++)
		begin
			waited = 0;
			while (!proc_valid)
			begin
				timed_step("proc_valid to rise");
			end
			check_value($sformatf("readout_word_%0d", i), 64'(expected_mem[PB_HALF + i]),
				64'(proc_data));
			repeat ($urandom_range(3, 0)) step(); // Processor stall
			proc_ack = 1'b1;
			waited = 0;
			while (proc_valid)
			begin
				timed_step("proc_valid to fall");
			end
			proc_ack = 1'b0;
		end

		// Reply words into the low addresses
		for (int i = 0; i < WRITE_WORDS; i++)
		begin
			repeat (4) step(); // Room for capture, write and address step
			word = PB_DW'($urandom());
			proc_wdata = word;
			proc_data_ready = 1'b1;
			repeat (1 + $urandom_range(1, 0)) step(); // One or two cycle strobe
			proc_data_ready = 1'b0;
			expected_mem[i] = word;
		end
		repeat (4) step(); // Last word lands
		proc_done = 1'b1;
		step();
		proc_done = 1'b0;

		for (int p = 0; p < NUM_PLAYERS; p++)
		begin
			waited = 0;
			while (!send_ship)
			begin
				timed_step("send_ship");
			end
			check_value($sformatf("tx_dest_%0d", p), 64'(p + 1), 64'(dest_address));
			check_value($sformatf("tx_base_%0d", p), 64'(p * PLAYER_BLOCK), 64'(player_base));
			base = p * PLAYER_BLOCK;
			tx_ready = 1'b0; // Engine busy with this block
			for (int i = 0; i < PLAYER_BLOCK; i++)
			begin
				tx_address = PB_AW'(base + i);
				step();
				check_value($sformatf("tx_word_%0d_%0d", p, i), 64'(expected_mem[base + i]),
					64'(pb_q)); // One cycle read latency
			end
			tx_ready = 1'b1; // Block done
		end
		repeat (4) step();
		$display("Simulation completed successfully");
		$finish;
	end

endmodule
